//--- src/busPkg.sv
package busPkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------
  localparam int addrWidth = 16;
  localparam int dataWidth = 8;

  // first fetch address
  localparam logic [addrWidth-1:0] resetPc = 16'h0000;

  // ----------------------------------------
  // cycle timing, one-hot rings
  // ----------------------------------------
  typedef enum logic [3:0] {
    T1 = 4'b0001,
    T2 = 4'b0010,  // stretched while wait_n low
    T3 = 4'b0100,
    T4 = 4'b1000   // opcode fetch only
  } tState_t;

  typedef enum logic [2:0] {
    M1 = 3'b001,   // opcode fetch
    M2 = 3'b010,
    M3 = 3'b100
  } mCycle_t;

  // external strobes
  typedef struct packed {
    logic m1;  // opcode fetch in progress
    logic rd;  // memory read
    logic wr;  // memory write
  } busCtrl_t;

endpackage

//--- src/cpuPkg.sv
package cpuPkg;

  // ----------------------------------------
  // instruction fields
  // ----------------------------------------
  // low eight values match the opcode alu field
  typedef enum logic [3:0] {
    ADD, ADC, SUB, SBC, AND, XOR, OR, CP,
    PASS  // operand b straight through
  } aluOp_t;

  typedef enum logic [2:0] {
    B, C, D, E, H, L, MEMHL, A
  } regCode_t;

  localparam logic [7:0] opNop  = 8'h00;
  localparam logic [7:0] opHalt = 8'h76;
  localparam logic [7:0] opJp   = 8'hC3;

  // ----------------------------------------
  // flag register layout
  // ----------------------------------------
  localparam int flagS  = 7;
  localparam int flagZ  = 6;
  localparam int flagH  = 4;
  localparam int flagPv = 2;
  localparam int flagN  = 1;
  localparam int flagC  = 0;

  localparam logic [7:0] accReset  = 8'hFF;
  localparam logic [7:0] flagReset = 8'hFF;

  typedef enum logic [1:0] {
    PC, HL, TMP
  } addrSel_t;

  // one machine cycle worth of control
  typedef struct packed {
    logic     lastM;
    logic     memRd;      // next cycle reads
    logic     memWr;      // next cycle writes
    addrSel_t addrSel;    // next cycle address
    logic     incPc;      // at end of T2
    regCode_t srcReg;
    logic     useDi;
    regCode_t dstReg;
    logic     writeDst;
    aluOp_t   aluOp;
    logic     setFlags;
    logic     loadTmpLo;
    logic     loadTmpHi;
    logic     jump;
    logic     halt;
  } microOp_t;

  typedef struct packed {
    logic [7:0]  acc;
    logic [7:0]  flags;
    logic [15:0] pc;
    logic [15:0] bc;
    logic [15:0] de;
    logic [15:0] hl;
  } cpuState_t;

endpackage

//--- src/cycleSequencer.sv
`timescale 1ns/1ps

module cycleSequencer (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             wait_n,
  input  logic             lastM,
  input  logic             halt,
  output busPkg::tState_t  tState,
  output busPkg::mCycle_t  mCycle,
  output logic             sampleEn,
  output logic             endM,
  output logic             haltN
);
  import busPkg::*;

  tState_t tNext;
  mCycle_t mNext;

  // ring successors
  always_comb
  begin
    case (tState)
      T1:      tNext = T2;
      T2:      tNext = T3;
      T3:      tNext = T4;
      default: tNext = T1;
    endcase
    case (mCycle)
      M1:      mNext = M2;
      M2:      mNext = M3;
      default: mNext = M1;
    endcase
  end

  assign sampleEn = haltN && (tState == T2) && wait_n;

  // fetch runs to T4, everything else ends in T3
  assign endM = haltN &&
                (((mCycle == M1) && (tState == T4)) ||
                 ((mCycle != M1) && (tState == T3)));

  // ----------------------------------------
  // state rings
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      tState <= T1;
      mCycle <= M1;
      haltN  <= 1'b1;
    end
    else if (haltN)
    begin
      if (endM)
      begin
        tState <= T1;
        if (halt)
        begin
          haltN  <= 1'b0;  // frozen until reset
          mCycle <= M1;
        end
        else if (lastM)
          mCycle <= M1;
        else
          mCycle <= mNext;
      end
      else if (!((tState == T2) && !wait_n))
        tState <= tNext;  // hold T2 on wait
    end
  end

  tOneHot: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot(tState));

  mOneHot: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot(mCycle));

endmodule

//--- src/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  logic [7:0]       ir,
  input  busPkg::mCycle_t  mCycle,
  output cpuPkg::microOp_t uop
);
  import busPkg::*;
  import cpuPkg::*;

  logic [1:0] x;
  logic [2:0] y;
  logic [2:0] z;
  logic       isLdRR, isLdRN, isLdRHl, isLdHlR;
  logic       isAluR, isAluHl, isAluN;
  logic       isImm, isHlRd;

  assign x = ir[7:6];
  assign y = ir[5:3];
  assign z = ir[2:0];

  // ----------------------------------------
  // instruction classes
  // ----------------------------------------
  always_comb
  begin
    isLdRR  = (x == 2'd1) && (y != 3'd6) && (z != 3'd6);
    isLdRHl = (x == 2'd1) && (y != 3'd6) && (z == 3'd6);
    isLdHlR = (x == 2'd1) && (y == 3'd6) && (z != 3'd6);
    isLdRN  = (x == 2'd0) && (y != 3'd6) && (z == 3'd6);
    isAluR  = (x == 2'd2) && (z != 3'd6);
    isAluHl = (x == 2'd2) && (z == 3'd6);
    isAluN  = (x == 2'd3) && (z == 3'd6);
    isImm   = isLdRN || isAluN;     // second byte from pc
    isHlRd  = isLdRHl || isAluHl;   // operand at (hl)
  end

  // ----------------------------------------
  // micro-operation per machine cycle
  // ----------------------------------------
  always_comb
  begin
    uop         = '0;
    uop.lastM   = 1'b1;
    uop.addrSel = PC;
    uop.srcReg  = regCode_t'(z);
    uop.dstReg  = regCode_t'(y);
    uop.aluOp   = PASS;

    if (isAluR || isAluHl || isAluN)
    begin
      uop.aluOp  = aluOp_t'({1'b0, y});
      uop.dstReg = A;  // cp hands back a unchanged
    end

    if (ir == opHalt)
      uop.halt = 1'b1;
    else if (ir == opJp)
    begin
      case (mCycle)
        M1:
        begin
          uop.lastM = 1'b0;
          uop.memRd = 1'b1;
        end
        M2:
        begin
          uop.lastM     = 1'b0;
          uop.memRd     = 1'b1;
          uop.incPc     = 1'b1;
          uop.loadTmpLo = 1'b1;
        end
        default:
        begin
          uop.addrSel   = TMP;  // next fetch from the target
          uop.incPc     = 1'b1;
          uop.loadTmpHi = 1'b1;
          uop.jump      = 1'b1;
        end
      endcase
    end
    else if (mCycle == M1)
    begin
      if (isImm || isHlRd || isLdHlR)
      begin
        uop.lastM   = 1'b0;
        uop.memRd   = isImm || isHlRd;
        uop.memWr   = isLdHlR;
        uop.addrSel = isImm ? PC : HL;
      end
      uop.writeDst = isLdRR || isAluR;
      uop.setFlags = isAluR;
    end
    else
    begin
      // second cycle with data back on di
      uop.incPc    = isImm;
      uop.useDi    = isImm || isHlRd;
      uop.writeDst = isImm || isHlRd;
      uop.setFlags = isAluHl || isAluN;
    end
  end

endmodule

//--- src/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
  input  cpuPkg::aluOp_t op,
  input  logic [7:0]     a,
  input  logic [7:0]     b,
  input  logic           carryIn,
  output logic [7:0]     result,
  output logic [7:0]     flagsOut
);
  import cpuPkg::*;

  logic       useCarry;
  logic       isSub;
  logic [4:0] nib;     // bit 4 is half carry or borrow
  logic [8:0] sum;
  logic       overflow;
  logic [7:0] flagSrc;

  always_comb
  begin
    useCarry = ((op == ADC) || (op == SBC)) && carryIn;
    isSub    = (op == SUB) || (op == SBC) || (op == CP);

    if (isSub)
    begin
      nib      = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'b0, useCarry};
      sum      = {1'b0, a} - {1'b0, b} - {8'b0, useCarry};
      overflow = (a[7] != b[7]) && (sum[7] != a[7]);
    end
    else
    begin
      nib      = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0, useCarry};
      sum      = {1'b0, a} + {1'b0, b} + {8'b0, useCarry};
      overflow = (a[7] == b[7]) && (sum[7] != a[7]);
    end

    flagsOut = '0;
    case (op)
      ADD, ADC, SUB, SBC, CP:
      begin
        result           = (op == CP) ? a : sum[7:0];
        flagsOut[flagH]  = nib[4];
        flagsOut[flagPv] = overflow;
        flagsOut[flagC]  = sum[8];
      end
      AND:
      begin
        result           = a & b;
        flagsOut[flagH]  = 1'b1;
        flagsOut[flagPv] = ~^result;  // even parity
      end
      XOR:
      begin
        result           = a ^ b;
        flagsOut[flagPv] = ~^result;
      end
      OR:
      begin
        result           = a | b;
        flagsOut[flagPv] = ~^result;
      end
      default: result = b;  // pass
    endcase

    // compare reports on the difference
    flagSrc         = (op == CP) ? sum[7:0] : result;
    flagsOut[flagS] = flagSrc[7];
    flagsOut[flagZ] = (flagSrc == 8'h00);
    flagsOut[flagN] = isSub;
  end

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic             clk,
  input  cpuPkg::regCode_t rdAddrA,
  input  cpuPkg::regCode_t rdAddrB,
  input  cpuPkg::regCode_t wrAddr,
  input  logic             we,
  input  logic [7:0]       wrData,
  output logic [7:0]       rdDataA,
  output logic [7:0]       rdDataB,
  output logic [15:0]      bc,
  output logic [15:0]      de,
  output logic [15:0]      hl
);
  import cpuPkg::*;

  logic [7:0] regs [6];  // b c d e h l

  always_ff @(posedge clk)
  begin
    if (we && (wrAddr < MEMHL))
      regs[wrAddr] <= wrData;
  end

  // codes 6 and 7 live outside this array
  assign rdDataA = (rdAddrA < MEMHL) ? regs[rdAddrA] : 8'h00;
  assign rdDataB = (rdAddrB < MEMHL) ? regs[rdAddrB] : 8'h00;

  assign bc = {regs[B], regs[C]};
  assign de = {regs[D], regs[E]};
  assign hl = {regs[H], regs[L]};

  wrPairOnly: assert property (@(posedge clk) we |-> (wrAddr < MEMHL));

endmodule

//--- src/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            wait_n,
  input  logic [busPkg::dataWidth-1:0]    di,
  output logic [busPkg::addrWidth-1:0]    addr,
  output logic [busPkg::dataWidth-1:0]    dout,
  output busPkg::busCtrl_t                bus,
  output logic                            haltN,
  output cpuPkg::cpuState_t               state
);
  import busPkg::*;
  import cpuPkg::*;

  tState_t    tState;
  mCycle_t    mCycle;
  logic       sampleEn, endM;
  microOp_t   uop;
  logic [15:0] pc, tmpAddr, hlAddr;
  logic [7:0]  ir, acc, flags, diLatch;
  logic [7:0]  opB, aluResult, aluFlags, rdDataA, rdDataB;
  logic [15:0] bc, de, hl;
  logic        rdCycle, wrCycle;  // kind of the running machine cycle
  logic        regWe;

  cycleSequencer seq (.clk, .reset_n, .wait_n, .lastM(uop.lastM), .halt(uop.halt),
                      .tState, .mCycle, .sampleEn, .endM, .haltN);

  instrDecoder dec (.ir, .mCycle, .uop);

  aluUnit alu (.op(uop.aluOp), .a(acc), .b(opB), .carryIn(flags[flagC]),
               .result(aluResult), .flagsOut(aluFlags));

  regFile regs (.clk, .rdAddrA(H), .rdAddrB(uop.srcReg), .wrAddr(uop.dstReg),
                .we(regWe), .wrData(aluResult), .rdDataA, .rdDataB, .bc, .de, .hl);

  // ----------------------------------------
  // operand and write select
  // ----------------------------------------
  always_comb
  begin
    if (uop.useDi)
      opB = diLatch;
    else if (uop.srcReg == A)
      opB = acc;
    else
      opB = rdDataB;
  end

  assign hlAddr = {rdDataA, hl[7:0]};  // high byte through port a
  assign regWe  = endM && uop.writeDst && (uop.dstReg != A) && (uop.dstReg != MEMHL);

  // ----------------------------------------
  // control registers
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      pc      <= resetPc;
      ir      <= opNop;
      acc     <= accReset;
      flags   <= flagReset;
      addr    <= resetPc;
      rdCycle <= 1'b1;  // first cycle is a fetch
      wrCycle <= 1'b0;
    end
    else
    begin
      if (sampleEn && rdCycle && (mCycle == M1))
        ir <= di;
      if (sampleEn && ((mCycle == M1) || uop.incPc))
        pc <= pc + 16'd1;

      if (endM)
      begin
        if (uop.jump)
          pc <= tmpAddr;
        if (uop.writeDst && (uop.dstReg == A))
          acc <= aluResult;
        if (uop.setFlags)
          flags <= aluFlags;

        case (uop.addrSel)  // next machine cycle
          HL:      addr <= hlAddr;
          TMP:     addr <= tmpAddr;
          default: addr <= pc;
        endcase
        rdCycle <= uop.lastM ? !uop.halt : uop.memRd;
        wrCycle <= !uop.lastM && uop.memWr;
      end
    end
  end

  // data path latches
  always_ff @(posedge clk)
  begin
    if (sampleEn && rdCycle)
      diLatch <= di;
    if (sampleEn && uop.loadTmpLo)
      tmpAddr[7:0] <= di;
    if (sampleEn && uop.loadTmpHi)
      tmpAddr[15:8] <= di;
    if (endM && !uop.lastM && uop.memWr)
      dout <= opB;  // ready from T1 of the write
  end

  // ----------------------------------------
  // strobes and observation
  // ----------------------------------------
  always_comb
  begin
    bus.m1 = rdCycle && (mCycle == M1) && ((tState == T1) || (tState == T2));
    bus.rd = rdCycle && ((tState == T1) || (tState == T2));
    bus.wr = wrCycle && (tState == T2);
  end

  assign state = '{acc: acc, flags: flags, pc: pc, bc: bc, de: de, hl: hl};

  rdWrExclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(bus.rd && bus.wr));

endmodule

//--- bench/refModel.svh
  logic [7:0]  prog [512];
  int          progLen;
  logic [7:0]  mMem [65536];
  logic [7:0]  mR [8];        // b c d e h l with index 6 unused
  logic [7:0]  mA, mF;
  logic [15:0] mPc;
  int          instrCount, totalClocks;
  logic [15:0] expAddrQ [$];
  logic [7:0]  expDataQ [$];

  // loads never target H or L so (HL) stays in the data area
  function automatic logic [2:0] pickDest();
    logic [2:0] d;
    d = 3'(nextRand() % 8);
    if ((d == 3'd4) || (d == 3'd5) || (d == 3'd6))
      d = 3'd7;
    return d;
  endfunction

  function automatic logic [2:0] pickSrc();
    logic [2:0] s;
    s = 3'(nextRand() % 8);
    if (s == 3'd6)
      s = 3'd7;
    return s;
  endfunction

  task automatic genProgram();
    int p;
    int k;
    int target;
    p = 0;
    for (int i = 0; i < 8; i++)
    begin
      if (i != 6)
      begin
        prog[p]     = {2'b00, 3'(i), 3'b110};
        prog[p + 1] = (i == 4) ? (8'h80 | 8'(nextRand())) : 8'(nextRand());
        p += 2;
      end
    end
    for (int i = 0; i < 60; i++)
    begin
      case (nextRand() % 8)
        0: prog[p] = {2'b01, pickDest(), pickSrc()};
        1: prog[p] = {2'b00, pickDest(), 3'b110};
        2: prog[p] = {2'b01, pickDest(), 3'b110};
        3: prog[p] = {2'b01, 3'b110, pickSrc()};
        4: prog[p] = {2'b10, 3'(nextRand()), pickSrc()};
        5: prog[p] = {2'b10, 3'(nextRand()), 3'b110};
        6: prog[p] = {2'b11, 3'(nextRand()), 3'b110};
        default:
        begin
          k      = int'(nextRand() % 3);
          target = p + 3 + k;  // forward over k nops
          prog[p]     = 8'hC3;
          prog[p + 1] = target[7:0];
          prog[p + 2] = target[15:8];
          for (int j = 0; j < k; j++)
            prog[p + 3 + j] = 8'h00;
          p = target - 1;
        end
      endcase
      // immediate operand for LD r,n and ALU n
      if ((prog[p][2:0] == 3'b110) && ((prog[p][7:6] == 2'b00) || (prog[p][7:6] == 2'b11)))
      begin
        prog[p + 1] = 8'(nextRand());
        p++;
      end
      p++;
    end
    prog[p] = 8'h76;
    progLen = p + 1;
  endtask

  // flag byte layout S Z - H - PV N C
  task automatic computeAlu(input int op, input int a, input int b, input int cin,
                            output logic [7:0] res, output logic [7:0] fl);
    int cv;
    int r;
    int h;
    int c;
    int ov;
    int pv;
    logic [7:0] sz;
    cv = ((op == 1) || (op == 3)) ? cin : 0;
    h  = 0;
    c  = 0;
    ov = 0;
    if (op <= 1)
    begin
      r  = a + b + cv;
      h  = ((a % 16) + (b % 16) + cv) > 15;
      c  = r > 255;
      ov = ((a >= 128) == (b >= 128)) && (((r % 256) >= 128) != (a >= 128));
    end
    else if ((op == 2) || (op == 3) || (op == 7))
    begin
      r  = a - b - cv + 256;
      h  = (a % 16) < ((b % 16) + cv);
      c  = a < (b + cv);
      ov = ((a >= 128) != (b >= 128)) && (((r % 256) >= 128) != (a >= 128));
    end
    else if (op == 4)
    begin
      r = a & b;
      h = 1;
    end
    else if (op == 5)
      r = a ^ b;
    else
      r = a | b;
    sz = 8'(r % 256);
    pv = (op >= 4 && op <= 6) ? !(^sz) : ov;
    res = (op == 7) ? 8'(a) : sz;
    fl = {sz[7], sz == 8'h00, 1'b0, 1'(h), 1'b0, 1'(pv),
          1'((op == 2) || (op == 3) || (op == 7)), 1'(c)};
  endtask

//--- bench/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb;
  logic              clk;
  logic              reset_n;
  logic              wait_n;
  logic [7:0]        di;
  logic [15:0]       addr;
  logic [7:0]        dout;
  busPkg::busCtrl_t  bus;
  logic              haltN;
  cpuPkg::cpuState_t state;

  logic [7:0]  mem [65536];
  int unsigned seed = 59278;
  int          mismatches, otherErrors;
  int          wrIdx, fetchCount;
  logic        monitorOn, m1Prev;

  function automatic int unsigned nextRand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 16;
  endfunction

  `include "refModel.svh"

  cpuCore DUT (.clk, .reset_n, .wait_n, .di, .addr, .dout, .bus, .haltN, .state);

  assign di = bus.rd ? mem[addr] : 8'hFF;

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [7:0] fillByte(int a);
    return 8'((a % 256) * 3) ^ 8'(a / 256) ^ 8'h5A;  // whole address
  endfunction

  function automatic logic [7:0] regOf(int i);
    return (i == 7) ? mA : mR[i];
  endfunction

  task automatic reportMismatch(string name, logic [15:0] exp, logic [15:0] act);
    $display("MISMATCH %s expected %h actual %h", name, exp, act);
    mismatches++;
  endtask

  // ----------------------------------------
  // instruction-level reference run
  // ----------------------------------------
  task automatic runModel();
    logic [7:0] op;
    logic [7:0] b;
    logic [7:0] res;
    logic [7:0] fl;
    logic [15:0] hlv;
    for (int i = 0; i < 65536; i++)
      mMem[i] = (i < progLen) ? prog[i] : fillByte(i);
    mA = 8'hFF;
    mF = 8'hFF;
    mPc = 16'h0000;
    instrCount = 0;
    totalClocks = 0;
    expAddrQ.delete();
    expDataQ.delete();
    while (instrCount < 1000)
    begin
      op = mMem[mPc];
      mPc++;
      instrCount++;
      hlv = {mR[4], mR[5]};
      if (op == 8'h76)
      begin
        totalClocks += 4;
        break;
      end
      else if (op == 8'hC3)
      begin
        mPc = {mMem[16'(mPc + 1)], mMem[mPc]};
        totalClocks += 10;
      end
      else if ((op[7:6] == 2'b01) && (op[5:3] == 3'd6))
      begin
        expAddrQ.push_back(hlv);  // LD (HL),r
        expDataQ.push_back(regOf(op[2:0]));
        mMem[hlv] = regOf(op[2:0]);
        totalClocks += 7;
      end
      else if ((op[7:6] == 2'b01) ||
               ((op[7:6] == 2'b00) && (op[5:3] != 3'd6) && (op[2:0] == 3'd6)))
      begin
        if (op[7:6] == 2'b00)
        begin
          b = mMem[mPc];
          mPc++;
        end
        else
          b = (op[2:0] == 3'd6) ? mMem[hlv] : regOf(op[2:0]);
        if (op[5:3] == 3'd7)
          mA = b;
        else
          mR[op[5:3]] = b;
        totalClocks += ((op[7:6] == 2'b01) && (op[2:0] != 3'd6)) ? 4 : 7;
      end
      else if ((op[7:6] == 2'b10) || ((op[7:6] == 2'b11) && (op[2:0] == 3'd6)))
      begin
        if (op[7:6] == 2'b11)
        begin
          b = mMem[mPc];
          mPc++;
        end
        else
          b = (op[2:0] == 3'd6) ? mMem[hlv] : regOf(op[2:0]);
        computeAlu(int'(op[5:3]), int'(mA), int'(b), int'(mF[0]), res, fl);
        mA = res;
        mF = fl;
        totalClocks += ((op[7:6] == 2'b10) && (op[2:0] != 3'd6)) ? 4 : 7;
      end
      else
        totalClocks += 4;  // treated as nop
    end
  endtask

  // memory writes and fetch count sampled before the edge updates
  always @(posedge clk)
  begin
    if (monitorOn)
    begin
      if (bus.wr && wait_n)
      begin
        if (wrIdx >= expAddrQ.size())
        begin
          $display("unexpected extra memory write to address %h", addr);
          otherErrors++;
        end
        else
        begin
          if (addr !== expAddrQ[wrIdx])
            reportMismatch("write address", expAddrQ[wrIdx], addr);
          if (dout !== expDataQ[wrIdx])
            reportMismatch("write data", 16'(expDataQ[wrIdx]), 16'(dout));
        end
        mem[addr] = dout;
        wrIdx++;
      end
      if (bus.m1 && !m1Prev)
        fetchCount++;
      m1Prev = bus.m1;
    end
  end

  // ----------------------------------------
  // one program run from reset to halt
  // ----------------------------------------
  task automatic runProgram(int runIdx, logic randomWait);
    int clocks;
    int limit;
    logic holdBad;
    logic [15:0] holdAddr;
    for (int i = 0; i < 65536; i++)
      mem[i] = (i < progLen) ? prog[i] : fillByte(i);
    monitorOn = 1'b0;
    wait_n = 1'b1;
    reset_n = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    reset_n = 1'b1;
    if (addr !== 16'h0000)
      reportMismatch("reset addr", 16'h0000, addr);
    if (bus.wr !== 1'b0)
      reportMismatch("reset wr", 16'h0, 16'(bus.wr));
    if (haltN !== 1'b1)
      reportMismatch("reset haltN", 16'h1, 16'(haltN));
    if (state.acc !== 8'hFF)
      reportMismatch("reset acc", 16'hFF, 16'(state.acc));
    if (state.flags !== 8'hFF)
      reportMismatch("reset flags", 16'hFF, 16'(state.flags));
    if (state.pc !== 16'h0000)
      reportMismatch("reset pc", 16'h0000, state.pc);

    wrIdx = 0;
    fetchCount = 0;
    m1Prev = 1'b0;
    monitorOn = 1'b1;
    clocks = 0;
    limit = randomWait ? totalClocks * 20 : totalClocks + 100;
    while ((haltN === 1'b1) && (clocks < limit))
    begin
      @(posedge clk);
      #2;
      clocks++;
      if (randomWait)
        wait_n = (nextRand() % 4) != 0;
    end
    wait_n = 1'b1;
    if (haltN !== 1'b0)
    begin
      $display("timeout in run %0d, core never halted", runIdx);
      otherErrors++;
      return;
    end

    if (!randomWait && (clocks != totalClocks))
      reportMismatch("run 1 clock count", 16'(totalClocks), 16'(clocks));
    if (state.acc !== mA)
      reportMismatch("final acc", 16'(mA), 16'(state.acc));
    if (state.flags !== mF)
      reportMismatch("final flags", 16'(mF), 16'(state.flags));
    if (state.pc !== mPc)
      reportMismatch("final pc", mPc, state.pc);
    if (state.bc !== {mR[0], mR[1]})
      reportMismatch("final bc", {mR[0], mR[1]}, state.bc);
    if (state.de !== {mR[2], mR[3]})
      reportMismatch("final de", {mR[2], mR[3]}, state.de);
    if (state.hl !== {mR[4], mR[5]})
      reportMismatch("final hl", {mR[4], mR[5]}, state.hl);
    if (wrIdx != expAddrQ.size())
      reportMismatch("write count", 16'(expAddrQ.size()), 16'(wrIdx));
    if (fetchCount != instrCount)
      reportMismatch("fetch count", 16'(instrCount), 16'(fetchCount));

    // bus stays quiet after halt
    holdAddr = addr;
    holdBad = 1'b0;
    for (int i = 0; (i < 50) && !holdBad; i++)
    begin
      @(posedge clk);
      #2;
      if (bus.rd || bus.wr)
      begin
        $display("bus strobe active %0d clocks after halt in run %0d", i + 1, runIdx);
        otherErrors++;
        holdBad = 1'b1;
      end
      if (addr !== holdAddr)
      begin
        reportMismatch("addr after halt", holdAddr, addr);
        holdBad = 1'b1;
      end
    end
    monitorOn = 1'b0;
  endtask

  initial
  begin
    reset_n = 1'b0;
    wait_n = 1'b1;
    monitorOn = 1'b0;
    m1Prev = 1'b0;
    mismatches = 0;
    otherErrors = 0;
    genProgram();
    runModel();
    runProgram(1, 1'b0);
    runProgram(2, 1'b1);
    $display("errors: %0d mismatches, %0d other", mismatches, otherErrors);
    if ((mismatches == 0) && (otherErrors == 0))
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- build.f
src/busPkg.sv
src/cpuPkg.sv
src/cycleSequencer.sv
src/instrDecoder.sv
src/aluUnit.sv
src/regFile.sv
src/cpuCore.sv
+incdir+bench
bench/cpuCoreTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module cpuCoreTb -o cpuCoreSim

./obj_dir/cpuCoreSim > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  exit 1
fi
